//--- tb/vtp_stim.txt
# w idx data | r idx expected_data | l/b vpn expected_hit expected_ppn | i cycles
# l adds a random 0..2 cycle gap after the lookup, b issues back to back
r 0 3000000000100f01
r 1 9a03c71e2b68f0d4
r 2 5d1c73a0e4b84f26
r 3 0
r 5 0
r 6 0
r 7 0
r 8 0
r 9 0
r a 0
r f 0
# count from here, one page in each lane
w 3 1
w 4 123456780
w 5 a00000001
w 4 123456785
w 5 a00000002
w 4 000abcdea
w 5 b12345678
w 4 fffffffff
w 5 00000ffff
i 4
l 123456780 1 a00000001
l 123456785 1 a00000002
l 000abcdea 1 b12345678
l fffffffff 1 00000ffff
l 000000004 0 0
l 1234567a0 0 0
b fffffffff 1 00000ffff
b 000abcdea 1 b12345678
b 123456785 1 a00000002
b 123456780 1 a00000001
b 000000004 0 0
i 5
r 7 8
r 8 3
r 9 4
# same lane and set, new tag, then invalidates
w 4 1234567a0
w 5 c00000003
i 4
l 123456780 0 0
l 1234567a0 1 c00000003
w 6 123456780
i 4
l 1234567a0 1 c00000003
w 6 1234567a0
i 4
l 1234567a0 0 0
l 123456785 1 a00000002
i 5
r 7 b
r 8 5
r 9 1234567a0
# flush every lane, counting stays on
w 3 3
i 4
l 123456785 0 0
l 000abcdea 0 0
l fffffffff 0 0
i 5
r 3 1
r 7 b
r 8 8
r 9 fffffffff
# counting off, counters hold
w 3 0
w 4 000abcdea
w 5 b12345678
i 4
l 000abcdea 1 b12345678
l 000000004 0 0
l 123456780 0 0
i 5
r 7 b
r 8 8
r 9 123456780
r 3 0

//--- verilog.f
src/vtp_pkg.sv
src/vtp_csr.sv
src/vtp_lane_dispatch.sv
src/vtp_tlb_lane.sv
src/vtp_rsp_merge.sv
src/vtp_top.sv
tb/tb_clock_gen.sv
tb/tb_vtp.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_vtp
FILELIST ?= verilog.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal -j 0

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)

.PHONY: sim clean

//--- tb/tb_vtp.sv
//////////////////////////////////////////////////////////////////////
// VTP testbench
// Replays CSR and lookup operations from the stimulus file and checks
// read data and translation responses against the expected values
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_vtp;

    import vtp_pkg::*;

    localparam logic [63:0] dfh_word = 64'h3000_0000_0010_0f01;
    localparam string stim_path = "tb/vtp_stim.txt";

    // Expected CSR read data, due in a known cycle
    typedef struct packed {
        int unsigned due;
        logic [csr_idx_bits-1:0] idx;
        logic [63:0] data;
    } exp_read_t;

    // Expected translation response, due in a known cycle
    typedef struct packed {
        int unsigned due;
        vtp_rsp_t rsp;
    } exp_rsp_t;

    logic clk;
    logic reset;
    logic rd_req_en;
    logic wr_req_en;
    logic [csr_idx_bits-1:0] csr_req_idx;
    logic [63:0] wr_data;
    logic [63:0] dfh_value;
    logic rd_rsp_valid;
    logic [63:0] rd_data;
    logic req_valid;
    vtp_req_t req;
    logic rsp_valid;
    vtp_rsp_t rsp;

    exp_read_t read_q[$];
    exp_rsp_t rsp_q[$];
    int value_errors = 0;
    int protocol_errors = 0;
    int unsigned cyc = 0;
    int unsigned cycle_limit = 0;

    tb_clock_gen clock0
    (
        .clk(clk),
        .reset(reset)
    );

    vtp_top dut0
    (
        .clk(clk),
        .reset(reset),
        .rd_req_en(rd_req_en),
        .wr_req_en(wr_req_en),
        .csr_req_idx(csr_req_idx),
        .wr_data(wr_data),
        .dfh_value(dfh_value),
        .rd_rsp_valid(rd_rsp_valid),
        .rd_data(rd_data),
        .req_valid(req_valid),
        .req(req),
        .rsp_valid(rsp_valid),
        .rsp(rsp)
    );

    task automatic check_csr(input csr_idx_e idx, input logic [63:0] got,
                             input logic [63:0] exp);
        if (got !== exp)
        begin
            $display("error: rd_data at index %0h is %h, expected %h", idx, got, exp);
            value_errors++;
        end
    endtask

    // The PPN only means something on a hit
    task automatic check_rsp(input vtp_rsp_t got, input vtp_rsp_t exp);
        if (got.hit !== exp.hit)
        begin
            $display("error: rsp.hit for vpn %h is %h, expected %h", exp.vpn, got.hit, exp.hit);
            value_errors++;
        end
        if (got.vpn !== exp.vpn)
        begin
            $display("error: rsp.vpn is %h, expected %h", got.vpn, exp.vpn);
            value_errors++;
        end
        if (exp.hit && (got.ppn !== exp.ppn))
        begin
            $display("error: rsp.ppn for vpn %h is %h, expected %h", exp.vpn, got.ppn, exp.ppn);
            value_errors++;
        end
    endtask

    // One clock of DUT inputs, applied just after the rising edge
    task automatic drive_cycle(input logic rd, input logic wr,
                               input logic [csr_idx_bits-1:0] idx, input logic [63:0] data,
                               input logic lookup, input logic [vpn_bits-1:0] vpn);
        @(posedge clk);
        rd_req_en <= rd;
        wr_req_en <= wr;
        csr_req_idx <= idx;
        wr_data <= data;
        req_valid <= lookup;
        req.vpn <= vpn;
    endtask

    task automatic drive_idle();
        drive_cycle(1'b0, 1'b0, '0, '0, 1'b0, '0);
    endtask

    // Still in the edge's active region after drive_cycle, so cyc is the
    // old count; the inputs are seen by the DUT in cycle cyc + 1
    task automatic run_op(input string line);
        byte op;
        logic [63:0] f1;
        logic [63:0] f2;
        logic [63:0] f3;
        int gap;
        exp_read_t er;
        exp_rsp_t el;

        op = line.getc(0);
        f1 = '0;
        f2 = '0;
        f3 = '0;
        void'($sscanf(line.substr(1, line.len() - 1), "%h %h %h", f1, f2, f3));
        case (op)
            "w":
            begin
                drive_cycle(1'b0, 1'b1, f1[csr_idx_bits-1:0], f2, 1'b0, '0);
            end
            "r":
            begin
                drive_cycle(1'b1, 1'b0, f1[csr_idx_bits-1:0], '0, 1'b0, '0);
                er.due = cyc + 2;
                er.idx = f1[csr_idx_bits-1:0];
                er.data = f2;
                read_q.push_back(er);
            end
            "l", "b":
            begin
                drive_cycle(1'b0, 1'b0, '0, '0, 1'b1, f1[vpn_bits-1:0]);
                // Dispatcher, lane and merger each add one register
                el.due = cyc + 4;
                el.rsp.hit = f2[0];
                el.rsp.ppn = f3[ppn_bits-1:0];
                el.rsp.vpn = f1[vpn_bits-1:0];
                rsp_q.push_back(el);
                if (op == "l")
                begin
                    gap = $urandom % 3;
                    repeat (gap) drive_idle();
                end
            end
            "i":
            begin
                repeat (int'(f1[15:0])) drive_idle();
            end
            default:
            begin
                $display("unknown operation in stimulus line: %s", line);
                protocol_errors++;
            end
        endcase
    endtask

    // Cycle count and watchdog
    always @(posedge clk)
    begin
        cyc <= cyc + 1;
        if ((cycle_limit != 0) && (cyc >= cycle_limit))
        begin
            $display("run stopped after %0d cycles before all operations finished", cyc);
            $display("errors: %0d wrong values, %0d protocol", value_errors, protocol_errors);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // Outputs are sampled mid-cycle where they are stable
    always @(negedge clk)
    begin
        if (!reset)
        begin
            if ((read_q.size() != 0) && (read_q[0].due == cyc))
            begin
                if (rd_rsp_valid)
                begin
                    check_csr(csr_idx_e'(read_q[0].idx), rd_data, read_q[0].data);
                end
                else
                begin
                    $display("read of index %0h got no response one cycle later",
                             read_q[0].idx);
                    protocol_errors++;
                end
                void'(read_q.pop_front());
            end
            else if (rd_rsp_valid)
            begin
                $display("read response arrived with no read outstanding");
                protocol_errors++;
            end

            if ((rsp_q.size() != 0) && (rsp_q[0].due == cyc))
            begin
                if (rsp_valid)
                begin
                    check_rsp(rsp, rsp_q[0].rsp);
                end
                else
                begin
                    $display("lookup of vpn %h got no response three cycles later",
                             rsp_q[0].rsp.vpn);
                    protocol_errors++;
                end
                void'(rsp_q.pop_front());
            end
            else if (rsp_valid)
            begin
                $display("translation response arrived with no lookup outstanding");
                protocol_errors++;
            end
        end
    end

    initial
    begin
        int fd;
        string line;
        string ops[$];

        rd_req_en = 1'b0;
        wr_req_en = 1'b0;
        csr_req_idx = '0;
        wr_data = '0;
        dfh_value = dfh_word;
        req_valid = 1'b0;
        req = '0;
        void'($urandom(32'hd20d_0265));

        fd = $fopen(stim_path, "r");
        if (fd == 0)
        begin
            $display("could not open the stimulus file %s", stim_path);
            $display("SOME TESTS FAILED");
            $finish;
        end
        else
        begin
            // Comment and blank lines carry no operation
            while ($fgets(line, fd) != 0)
            begin
                if ((line.len() > 1) && (line.getc(0) != "#"))
                begin
                    ops.push_back(line);
                end
            end
            $fclose(fd);
            cycle_limit = 16 * ops.size() + 100;

            @(negedge reset);
            foreach (ops[i])
            begin
                run_op(ops[i]);
            end

            // Let everything in flight land, then watch a little longer for strays
            while ((read_q.size() != 0) || (rsp_q.size() != 0))
            begin
                drive_idle();
            end
            repeat (4) drive_idle();

            $display("errors: %0d wrong values, %0d protocol", value_errors, protocol_errors);
            if ((value_errors == 0) && (protocol_errors == 0))
            begin
                $display("ALL TESTS PASSED");
            end
            else
            begin
                $display("SOME TESTS FAILED");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- tb/tb_clock_gen.sv
//////////////////////////////////////////////////////////////////////
// Testbench clock and reset
// 10 ns clock, reset held high for the first 10 rising edges
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen
(
    output logic clk,
    output logic reset
);

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Reset leaves on a rising edge, like any other registered input
    initial
    begin
        reset = 1'b1;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

//--- src/vtp_top.sv
//////////////////////////////////////////////////////////////////////
// VTP top level
// CSR block, lane dispatcher, the array of TLB lanes and the
// response merger
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module vtp_top
(
    input  logic clk,
    input  logic reset,

    // Generic CSR port
    input  logic rd_req_en,
    input  logic wr_req_en,
    input  logic [vtp_pkg::csr_idx_bits-1:0] csr_req_idx,
    input  logic [63:0] wr_data,
    input  logic [63:0] dfh_value,
    output logic rd_rsp_valid,
    output logic [63:0] rd_data,

    // Translation lookups, answered three cycles later
    input  logic req_valid,
    input  vtp_pkg::vtp_req_t req,
    output logic rsp_valid,
    output vtp_pkg::vtp_rsp_t rsp
);

    import vtp_pkg::*;

    vtp_ctrl_t ctrl;
    vtp_events_t events;
    vtp_lane_req_t [n_lanes-1:0] lane_req;
    vtp_lane_rsp_t [n_lanes-1:0] lane_rsp;

    vtp_csr csr0
    (
        .clk(clk),
        .reset(reset),
        .rd_req_en(rd_req_en),
        .wr_req_en(wr_req_en),
        .csr_req_idx(csr_req_idx),
        .wr_data(wr_data),
        .dfh_value(dfh_value),
        .rd_rsp_valid(rd_rsp_valid),
        .rd_data(rd_data),
        .events(events),
        .ctrl(ctrl)
    );

    vtp_lane_dispatch dispatch0
    (
        .clk(clk),
        .reset(reset),
        .req_valid(req_valid),
        .req(req),
        .ctrl(ctrl),
        .lane_req(lane_req)
    );

    // One TLB slice per lane, each serving the VPNs with its low bits
    for (genvar i = 0; i < n_lanes; i++)
    begin : g_lane
        vtp_tlb_lane #(.lane_id(i)) lane
        (
            .clk(clk),
            .reset(reset),
            .lane_req(lane_req[i]),
            .lane_rsp(lane_rsp[i])
        );
    end

    vtp_rsp_merge merge0
    (
        .clk(clk),
        .reset(reset),
        .lane_rsp(lane_rsp),
        .rsp_valid(rsp_valid),
        .rsp(rsp),
        .events(events)
    );

endmodule

`default_nettype wire

//--- src/vtp_rsp_merge.sv
//////////////////////////////////////////////////////////////////////
// VTP response merger
// Drains the lane results into one registered response stream and
// raises hit/miss events for the statistics
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module vtp_rsp_merge
(
    input  logic clk,
    input  logic reset,

    input  vtp_pkg::vtp_lane_rsp_t [vtp_pkg::n_lanes-1:0] lane_rsp,

    output logic rsp_valid,
    output vtp_pkg::vtp_rsp_t rsp,
    output vtp_pkg::vtp_events_t events
);

    import vtp_pkg::*;

    logic [n_lanes-1:0] lane_valid;
    vtp_lane_rsp_t sel_rsp;
    logic any_valid;

    // At most one lane answers per cycle, so a priority pick is enough
    always_comb
    begin
        sel_rsp = '0;
        for (int i = 0; i < n_lanes; i++)
        begin
            lane_valid[i] = lane_rsp[i].valid;
            if (lane_rsp[i].valid)
            begin
                sel_rsp = lane_rsp[i];
            end
        end
    end

    assign any_valid = |lane_valid;

    always_ff @(posedge clk)
    begin
        rsp_valid <= any_valid;
        rsp.hit <= sel_rsp.hit;
        rsp.ppn <= sel_rsp.ppn;
        rsp.vpn <= sel_rsp.vpn;

        // Events leave in step with the response they describe
        events.hit <= any_valid && sel_rsp.hit;
        events.miss <= any_valid && !sel_rsp.hit;
        events.miss_vpn <= sel_rsp.vpn;

        if (reset)
        begin
            rsp_valid <= 1'b0;
            events.hit <= 1'b0;
            events.miss <= 1'b0;
        end
    end

    // The dispatcher steers each lookup to one lane, so responses never overlap
    assert property (@(posedge clk) disable iff (reset) $onehot0(lane_valid))
        else $error("more than one lane response valid");

endmodule

`default_nettype wire

//--- src/vtp_tlb_lane.sv
//////////////////////////////////////////////////////////////////////
// VTP TLB lane
// One direct-mapped slice of the TLB with registered lookup, insert,
// per-page invalidate and full flush
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module vtp_tlb_lane
#(
    // Position of this slice, which is also the low VPN bits it serves
    parameter int unsigned lane_id = 0
)
(
    input  logic clk,
    input  logic reset,

    input  vtp_pkg::vtp_lane_req_t lane_req,
    output vtp_pkg::vtp_lane_rsp_t lane_rsp
);

    import vtp_pkg::*;

    logic [lane_sets-1:0] valid_q;
    logic [tag_bits-1:0] tag_q [lane_sets];
    logic [ppn_bits-1:0] ppn_q [lane_sets];

    logic upd_tag_match;

    assign upd_tag_match = (tag_q[lane_req.update.set_idx] == lane_req.update.tag);

    // Valid bits; a flush or a reset empties the whole slice
    always_ff @(posedge clk)
    begin
        if (lane_req.insert_valid)
        begin
            valid_q[lane_req.update.set_idx] <= 1'b1;
        end
        else if (lane_req.inval_valid && upd_tag_match)
        begin
            // Leave the set alone if another page now lives in it
            valid_q[lane_req.update.set_idx] <= 1'b0;
        end

        if (reset || lane_req.inval_all)
        begin
            valid_q <= '0;
        end
    end

    // Tag and PPN storage, overwritten on insert
    always_ff @(posedge clk)
    begin
        if (lane_req.insert_valid)
        begin
            tag_q[lane_req.update.set_idx] <= lane_req.update.tag;
            ppn_q[lane_req.update.set_idx] <= lane_req.ppn;
        end
    end

    // Lookup reads the arrays before any update in this cycle takes effect
    always_ff @(posedge clk)
    begin
        lane_rsp.valid <= lane_req.lookup_valid;
        lane_rsp.hit <= valid_q[lane_req.lookup.set_idx] &&
                        (tag_q[lane_req.lookup.set_idx] == lane_req.lookup.tag);
        lane_rsp.ppn <= ppn_q[lane_req.lookup.set_idx];
        // Rebuild the full VPN from the pieces this lane stands for
        lane_rsp.vpn <= {lane_req.lookup.tag, lane_req.lookup.set_idx, lane_bits'(lane_id)};

        if (reset)
        begin
            lane_rsp.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- src/vtp_lane_dispatch.sv
//////////////////////////////////////////////////////////////////////
// VTP lane dispatcher
// Registers lookups and control pulses and steers each one to the
// TLB lane that owns the page
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module vtp_lane_dispatch
(
    input  logic clk,
    input  logic reset,

    input  logic req_valid,
    input  vtp_pkg::vtp_req_t req,
    input  vtp_pkg::vtp_ctrl_t ctrl,

    output vtp_pkg::vtp_lane_req_t [vtp_pkg::n_lanes-1:0] lane_req
);

    import vtp_pkg::*;

    logic [vpn_bits-1:0] upd_vpn;
    logic [n_lanes-1:0] lookup_valids;

    // Insert and invalidate come from separate CSR writes, never together
    assign upd_vpn = ctrl.insert_valid ? ctrl.insert_vpn : ctrl.inval_vpn;

    always_ff @(posedge clk)
    begin
        for (int i = 0; i < n_lanes; i++)
        begin
            // Set, tag and PPN go to every lane; only the valid bits are steered
            lane_req[i].lookup <= vpn_addr(req.vpn);
            lane_req[i].update <= vpn_addr(upd_vpn);
            lane_req[i].ppn <= ctrl.insert_ppn;

            lane_req[i].lookup_valid <= req_valid && (vpn_lane(req.vpn) == lane_bits'(i));
            lane_req[i].insert_valid <= ctrl.insert_valid &&
                                        (vpn_lane(upd_vpn) == lane_bits'(i));
            lane_req[i].inval_valid <= ctrl.inval_valid &&
                                       (vpn_lane(upd_vpn) == lane_bits'(i));
            lane_req[i].inval_all <= ctrl.inval_all;

            if (reset)
            begin
                lane_req[i].lookup_valid <= 1'b0;
                lane_req[i].insert_valid <= 1'b0;
                lane_req[i].inval_valid <= 1'b0;
                lane_req[i].inval_all <= 1'b0;
            end
        end
    end

    always_comb
    begin
        for (int i = 0; i < n_lanes; i++)
        begin
            lookup_valids[i] = lane_req[i].lookup_valid;
        end
    end

    // A lookup lands in exactly one lane, and only after a request
    assert property (@(posedge clk) disable iff (reset)
                     $onehot0(lookup_valids) && ((|lookup_valids) -> $past(req_valid)))
        else $error("lookup steered to more than one lane");

endmodule

`default_nettype wire

//--- src/vtp_csr.sv
//////////////////////////////////////////////////////////////////////
// VTP CSR block
// Maps the generic 64-bit CSR port onto the mode register, insert and
// invalidate pulses, and the hit/miss statistics
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module vtp_csr
(
    input  logic clk,
    input  logic reset,

    input  logic rd_req_en,
    input  logic wr_req_en,
    input  logic [vtp_pkg::csr_idx_bits-1:0] csr_req_idx,
    input  logic [63:0] wr_data,
    // The master owns the MMIO map, so it supplies the DFH
    input  logic [63:0] dfh_value,
    output logic rd_rsp_valid,
    output logic [63:0] rd_data,

    input  vtp_pkg::vtp_events_t events,
    output vtp_pkg::vtp_ctrl_t ctrl
);

    import vtp_pkg::*;

    logic count_en;
    logic [stat_bits-1:0] stat_hits;
    logic [stat_bits-1:0] stat_misses;
    logic [vpn_bits-1:0] last_miss_vpn;
    logic [vpn_bits-1:0] insert_vpn_q;
    logic [63:0] mode_value;

    logic wr_req_en_q;
    csr_idx_e wr_idx_q;
    logic [63:0] wr_data_q;

    // Only count_en is kept; inval_all is gone by the time it can be read
    always_comb
    begin
        mode_value = 64'b0;
        mode_value[mode_count_en] = count_en;
    end

    // Read mux, answered one cycle after the strobe
    always_ff @(posedge clk)
    begin
        rd_rsp_valid <= rd_req_en;

        case (csr_idx_e'(csr_req_idx))
            csr_dfh:
                rd_data <= dfh_value;
            csr_id_lo:
                rd_data <= vtp_block_id[63:0];
            csr_id_hi:
                rd_data <= vtp_block_id[127:64];
            csr_mode:
                rd_data <= mode_value;
            csr_stat_hits:
                rd_data <= 64'(stat_hits);
            csr_stat_misses:
                rd_data <= 64'(stat_misses);
            csr_last_miss_vpn:
                rd_data <= 64'(last_miss_vpn);
            default:
                rd_data <= 64'b0;
        endcase

        if (reset)
        begin
            rd_rsp_valid <= 1'b0;
        end
    end

    // Writes sit in a buffer stage for one cycle before decode
    always_ff @(posedge clk)
    begin
        wr_req_en_q <= wr_req_en;
        wr_idx_q <= csr_idx_e'(csr_req_idx);
        wr_data_q <= wr_data;

        if (reset)
        begin
            wr_req_en_q <= 1'b0;
        end
    end

    // Insert VPN is only staged here and the PPN write fires the insert
    always_ff @(posedge clk)
    begin
        if (wr_req_en_q && (wr_idx_q == csr_insert_vpn))
        begin
            insert_vpn_q <= wr_data_q[vpn_bits-1:0];
        end
    end

    // Decode into the mode level and the single-cycle control pulses
    always_ff @(posedge clk)
    begin
        if (wr_req_en_q && (wr_idx_q == csr_mode))
        begin
            count_en <= wr_data_q[mode_count_en];
        end

        ctrl.insert_vpn <= insert_vpn_q;
        ctrl.insert_ppn <= wr_data_q[ppn_bits-1:0];
        ctrl.insert_valid <= wr_req_en_q && (wr_idx_q == csr_insert_ppn);

        ctrl.inval_vpn <= wr_data_q[vpn_bits-1:0];
        ctrl.inval_valid <= wr_req_en_q && (wr_idx_q == csr_inval_vpn);

        // A mode write with inval_all set flushes every lane once
        ctrl.inval_all <= wr_req_en_q && (wr_idx_q == csr_mode) &&
                          wr_data_q[mode_inval_all];

        if (reset)
        begin
            count_en <= 1'b0;
            ctrl.insert_valid <= 1'b0;
            ctrl.inval_valid <= 1'b0;
            ctrl.inval_all <= 1'b0;
        end
    end

    // Statistics; the last miss is captured even while counting is off
    always_ff @(posedge clk)
    begin
        if (count_en && events.hit)
        begin
            stat_hits <= stat_hits + 1'b1;
        end

        if (count_en && events.miss)
        begin
            stat_misses <= stat_misses + 1'b1;
        end

        if (events.miss)
        begin
            last_miss_vpn <= events.miss_vpn;
        end

        if (reset)
        begin
            stat_hits <= '0;
            stat_misses <= '0;
            last_miss_vpn <= '0;
        end
    end

    // The master never issues a read and a write in the same cycle
    assert property (@(posedge clk) disable iff (reset) !(rd_req_en && wr_req_en))
        else $error("CSR read and write requested together");

endmodule

`default_nettype wire

//--- src/vtp_pkg.sv
//////////////////////////////////////////////////////////////////////
// VTP shared definitions
// Sizes, CSR register map, mode bits, block ID and the packed
// structs that carry requests, control pulses and events
//////////////////////////////////////////////////////////////////////

`default_nettype none

package vtp_pkg;

    // Lane and set geometry of the distributed TLB
    localparam int n_lanes = 4;
    localparam int lane_bits = 2;
    localparam int lane_sets = 8;
    localparam int set_bits = 3;

    // 4 KB pages, so a VPN and a PPN are both 48 - 12 bits
    localparam int vpn_bits = 36;
    localparam int ppn_bits = 36;
    localparam int tag_bits = vpn_bits - lane_bits - set_bits;

    localparam int stat_bits = 48;
    localparam int csr_idx_bits = 4;

    localparam logic [127:0] vtp_block_id = 128'h5d1c_73a0_e4b8_4f26_9a03_c71e_2b68_f0d4;

    // 64-bit CSR slots; indices not named here read as zero
    typedef enum logic [csr_idx_bits-1:0] {
        csr_dfh = 4'd0,
        csr_id_lo = 4'd1,
        csr_id_hi = 4'd2,
        csr_mode = 4'd3,
        csr_insert_vpn = 4'd4,
        csr_insert_ppn = 4'd5,
        csr_inval_vpn = 4'd6,
        csr_stat_hits = 4'd7,
        csr_stat_misses = 4'd8,
        csr_last_miss_vpn = 4'd9
    } csr_idx_e;

    // Bit positions within the mode register
    typedef enum logic [5:0] {
        mode_count_en = 6'd0,
        mode_inval_all = 6'd1
    } mode_bit_e;

    typedef struct packed {
        logic [vpn_bits-1:0] vpn;
    } vtp_req_t;

    typedef struct packed {
        logic insert_valid;
        logic [vpn_bits-1:0] insert_vpn;
        logic [ppn_bits-1:0] insert_ppn;
        logic inval_valid;
        logic [vpn_bits-1:0] inval_vpn;
        logic inval_all;
    } vtp_ctrl_t;

    // Position of a page inside one lane
    typedef struct packed {
        logic [set_bits-1:0] set_idx;
        logic [tag_bits-1:0] tag;
    } vtp_lane_addr_t;

    // A lookup and an update may reach a lane in the same cycle, so each
    // has its own set and tag
    typedef struct packed {
        logic lookup_valid;
        logic insert_valid;
        logic inval_valid;
        logic inval_all;
        vtp_lane_addr_t lookup;
        vtp_lane_addr_t update;
        logic [ppn_bits-1:0] ppn;
    } vtp_lane_req_t;

    typedef struct packed {
        logic valid;
        logic hit;
        logic [ppn_bits-1:0] ppn;
        logic [vpn_bits-1:0] vpn;
    } vtp_lane_rsp_t;

    typedef struct packed {
        logic hit;
        logic [ppn_bits-1:0] ppn;
        logic [vpn_bits-1:0] vpn;
    } vtp_rsp_t;

    typedef struct packed {
        logic hit;
        logic miss;
        logic [vpn_bits-1:0] miss_vpn;
    } vtp_events_t;

    // Lowest VPN bits pick the lane, the next ones the set, the rest is the tag
    function automatic logic [lane_bits-1:0] vpn_lane(input logic [vpn_bits-1:0] vpn);
        return vpn[lane_bits-1:0];
    endfunction

    function automatic vtp_lane_addr_t vpn_addr(input logic [vpn_bits-1:0] vpn);
        vtp_lane_addr_t addr;
        addr.set_idx = vpn[lane_bits +: set_bits];
        addr.tag = vpn[vpn_bits-1 -: tag_bits];
        return addr;
    endfunction

endpackage

`default_nettype wire
